// ==== Makefile ====
SIM := obj_dir/Vtb_execution

.PHONY: all run clean

all: run

$(SIM): filelist.f $(wildcard *.sv) $(wildcard *.svh)
	verilator --binary --timing -f filelist.f --top-module tb_execution -o Vtb_execution

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== branch_unit.sv ====
`default_nettype none
`include "exe_consts.svh"

module branch_unit (
    exe_op_if.unit               op,
    output logic                 taken_o,
    output logic [`EXE_XLEN-1:0] target_o,
    output logic [`EXE_XLEN-1:0] link_o,
    output logic                 misaligned_o
);
    import exe_pkg::*;

    logic [`EXE_XLEN-1:0] imm_b;
    logic [`EXE_XLEN-1:0] imm_j;
    logic [`EXE_XLEN-1:0] imm_i;
    logic [`EXE_XLEN-1:0] jalr_sum;
    logic                 cond;

    // Immediates of the B, J and I formats
    assign imm_b = {{(`EXE_XLEN-13){op.inst[31]}}, op.inst[31], op.inst[7],
                    op.inst[30:25], op.inst[11:8], 1'b0};
    assign imm_j = {{(`EXE_XLEN-21){op.inst[31]}}, op.inst[31], op.inst[19:12],
                    op.inst[20], op.inst[30:21], 1'b0};
    assign imm_i = {{(`EXE_XLEN-12){op.inst[31]}}, op.inst[31:20]};

    assign jalr_sum = op.src1 + imm_i;

    // Branch condition from funct3
    always_comb begin
        case (op.inst[14:12])
            3'b000:  cond = (op.src1 == op.src2);
            3'b001:  cond = (op.src1 != op.src2);
            3'b100:  cond = ($signed(op.src1) < $signed(op.src2));
            3'b101:  cond = ($signed(op.src1) >= $signed(op.src2));
            3'b110:  cond = (op.src1 < op.src2);
            3'b111:  cond = (op.src1 >= op.src2);
            default: cond = 1'b0;
        endcase
    end

    always_comb begin
        taken_o  = 1'b0;
        target_o = op.pc + imm_b;
        case (op.unit_sel)
            UNIT_BRANCH: taken_o = op.valid & cond;
            UNIT_JAL: begin
                taken_o  = op.valid;
                target_o = op.pc + imm_j;
            end
            UNIT_JALR: begin
                taken_o  = op.valid;
                target_o = {jalr_sum[`EXE_XLEN-1:1], 1'b0};
            end
            default: taken_o = 1'b0;
        endcase
    end

    assign link_o = op.pc + `EXE_XLEN'd4;

    // No compressed extension, so a target must be word aligned
    assign misaligned_o = taken_o & (target_o[1:0] != 2'b00);

endmodule

`default_nettype wire

// ==== exe_consts.svh ====
`ifndef EXE_CONSTS_SVH
`define EXE_CONSTS_SVH

// ----------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------

// Data and address width of the RV32 core
`define EXE_XLEN 32

// Register file index width
`define EXE_REGW 5

// ----------------------------------------------------------
// Exception cause codes
// ----------------------------------------------------------

// Values follow the privileged spec mcause encoding
`define CAUSE_MISALIGNED_FETCH 32'd0
`define CAUSE_MISALIGNED_LOAD  32'd4
`define CAUSE_FAULT_LOAD       32'd5
`define CAUSE_MISALIGNED_STORE 32'd6
`define CAUSE_FAULT_STORE      32'd7

`endif

// ==== exe_op_if.sv ====
`default_nettype none
`include "exe_consts.svh"

// Issued operation, with operands already forwarded
interface exe_op_if;
    import exe_pkg::*;

    logic                 valid;
    exe_unit_e            unit_sel;
    alu_op_e              alu_op;
    logic                 use_imm;
    logic [`EXE_XLEN-1:0] pc;
    logic [31:0]          inst;
    logic [`EXE_XLEN-1:0] src1;
    logic [`EXE_XLEN-1:0] src2;

    // Stage top side
    modport issue (output valid, unit_sel, alu_op, use_imm, pc, inst, src1, src2);

    // Execution units side
    modport unit (input valid, unit_sel, alu_op, use_imm, pc, inst, src1, src2);

endinterface

`default_nettype wire

// ==== exe_pkg.sv ====
`default_nettype none

package exe_pkg;

    // Functional unit that takes the decoded instruction
    typedef enum logic [2:0] {
        UNIT_NONE,
        UNIT_INT,
        UNIT_BRANCH,
        UNIT_JAL,
        UNIT_JALR,
        UNIT_LOAD,
        UNIT_STORE,
        UNIT_CSR
    } exe_unit_e;

    // Integer ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_LUI,
        ALU_AUIPC
    } alu_op_e;

    // Data memory request FSM
    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_REQ,
        MEM_WAIT
    } mem_state_e;

endpackage

`default_nettype wire

// ==== execution.sv ====
`default_nettype none
`include "exe_consts.svh"

module execution (
    input  wire                     clk_i,
    input  wire                     rst_n_i,
    input  wire                     valid_i,
    input  wire [`EXE_XLEN-1:0]     pc_i,
    input  wire [31:0]              inst_i,
    input  wire exe_pkg::exe_unit_e unit_i,
    input  wire exe_pkg::alu_op_e   alu_op_i,
    input  wire                     use_imm_i,
    input  wire [`EXE_XLEN-1:0]     src1_data_i,
    input  wire [`EXE_XLEN-1:0]     src2_data_i,
    input  wire                     xcpt_i,
    input  wire [`EXE_XLEN-1:0]     xcpt_cause_i,
    input  wire                     dmem_req_ready_i,
    input  wire                     dmem_resp_valid_i,
    input  wire                     dmem_resp_nack_i,
    input  wire [`EXE_XLEN-1:0]     dmem_resp_data_i,
    input  wire                     dmem_xcpt_ma_i,
    input  wire                     dmem_xcpt_pf_i,
    output logic                    exe_lock_o,
    output logic                    wb_valid_o,
    output logic [`EXE_XLEN-1:0]    wb_pc_o,
    output logic                    wb_we_o,
    output logic [`EXE_REGW-1:0]    wb_reg_o,
    output logic [`EXE_XLEN-1:0]    wb_data_o,
    output logic                    branch_taken_o,
    output logic [`EXE_XLEN-1:0]    branch_target_o,
    output logic                    xcpt_o,
    output logic [`EXE_XLEN-1:0]    xcpt_cause_o,
    output logic                    dmem_req_valid_o,
    output logic                    dmem_req_we_o,
    output logic [1:0]              dmem_req_size_o,
    output logic [`EXE_XLEN-1:0]    dmem_req_addr_o,
    output logic [`EXE_XLEN-1:0]    dmem_req_data_o
);
    import exe_pkg::*;

    logic [`EXE_REGW-1:0] rs1, rs2, rd;
    logic [`EXE_XLEN-1:0] src1_fwd, src2_fwd;
    logic [`EXE_XLEN-1:0] int_result, br_target, br_link, mem_data;
    logic                 br_taken, br_misaligned;
    logic                 mem_done, mem_busy, mem_xcpt, mem_fin;
    logic                 is_mem, is_store;
    logic                 xcpt;
    logic [`EXE_XLEN-1:0] xcpt_cause;
    logic                 rd_write, we_d, wb_valid_d;
    logic [`EXE_XLEN-1:0] data_d;

    assign rs1 = inst_i[19:15];
    assign rs2 = inst_i[24:20];
    assign rd  = inst_i[11:7];

    // Write-back forwarding into both operands
    assign src1_fwd = (wb_we_o && wb_reg_o == rs1) ? wb_data_o : src1_data_i;
    assign src2_fwd = (wb_we_o && wb_reg_o == rs2) ? wb_data_o : src2_data_i;

    exe_op_if op_if ();

    assign op_if.valid    = valid_i;
    assign op_if.unit_sel = unit_i;
    assign op_if.alu_op   = alu_op_i;
    assign op_if.use_imm  = use_imm_i;
    assign op_if.pc       = pc_i;
    assign op_if.inst     = inst_i;
    assign op_if.src1     = src1_fwd;
    assign op_if.src2     = src2_fwd;

    int_unit u_int_unit (.op(op_if), .int_result_o(int_result));

    branch_unit u_branch_unit (
        .op(op_if), .taken_o(br_taken), .target_o(br_target),
        .link_o(br_link), .misaligned_o(br_misaligned)
    );

    mem_unit u_mem_unit (
        .clk_i, .rst_n_i, .op(op_if), .xcpt_i,
        .dmem_req_ready_i, .dmem_resp_valid_i, .dmem_resp_nack_i, .dmem_resp_data_i,
        .dmem_xcpt_ma_i, .dmem_xcpt_pf_i,
        .dmem_req_valid_o, .dmem_req_we_o, .dmem_req_size_o, .dmem_req_addr_o,
        .dmem_req_data_o,
        .mem_busy_o(mem_busy), .mem_done_o(mem_done), .mem_data_o(mem_data),
        .mem_xcpt_o(mem_xcpt)
    );

    assign is_store = (unit_i == UNIT_STORE);
    assign is_mem   = (unit_i == UNIT_LOAD) | is_store;
    assign mem_fin  = mem_done | mem_xcpt;

    // Decode holds its inputs until the final response of a load or store
    assign exe_lock_o = (valid_i & is_mem & ~xcpt_i & ~mem_busy) | (mem_busy & ~mem_fin);

    // ----------------------------------------------------------
    // Exception priority
    // ----------------------------------------------------------

    always_comb begin
        xcpt = 1'b1;
        if (xcpt_i)                                   xcpt_cause = xcpt_cause_i;
        else if (br_misaligned)                       xcpt_cause = `CAUSE_MISALIGNED_FETCH;
        else if (mem_xcpt & is_store & dmem_xcpt_ma_i)  xcpt_cause = `CAUSE_MISALIGNED_STORE;
        else if (mem_xcpt & ~is_store & dmem_xcpt_ma_i) xcpt_cause = `CAUSE_MISALIGNED_LOAD;
        else if (mem_xcpt & is_store & dmem_xcpt_pf_i)  xcpt_cause = `CAUSE_FAULT_STORE;
        else if (mem_xcpt & ~is_store & dmem_xcpt_pf_i) xcpt_cause = `CAUSE_FAULT_LOAD;
        else begin
            xcpt       = 1'b0;
            xcpt_cause = '0;
        end
    end

    // ----------------------------------------------------------
    // Result select and write-back register
    // ----------------------------------------------------------

    always_comb begin
        rd_write = 1'b1;
        case (unit_i)
            UNIT_INT:             data_d = int_result;
            UNIT_JAL, UNIT_JALR:  data_d = br_link;
            UNIT_LOAD:            data_d = mem_data;
            // CSR ops pass rs1 through, funct3[2] picks the immediate form
            UNIT_CSR: data_d = inst_i[14] ? {{(`EXE_XLEN-`EXE_REGW){1'b0}}, rs1} : src1_fwd;
            default: begin
                rd_write = 1'b0;
                data_d   = '0;
            end
        endcase
    end

    assign we_d = rd_write & (rd != '0) & ~xcpt;

    // Non-memory ops and refused memory ops retire at once
    assign wb_valid_d = (valid_i & (~is_mem | xcpt_i)) | mem_fin;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wb_valid_o     <= 1'b0;
            wb_we_o        <= 1'b0;
            xcpt_o         <= 1'b0;
            branch_taken_o <= 1'b0;
        end else begin
            wb_valid_o     <= wb_valid_d;
            wb_we_o        <= wb_valid_d & we_d;
            xcpt_o         <= wb_valid_d & xcpt;
            // A trap overrides the redirect
            branch_taken_o <= wb_valid_d & br_taken & ~xcpt;
        end
    end

    always_ff @(posedge clk_i) begin
        if (wb_valid_d) begin
            wb_pc_o         <= pc_i;
            wb_reg_o        <= rd;
            wb_data_o       <= data_d;
            branch_target_o <= br_target;
            xcpt_cause_o    <= xcpt_cause;
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
exe_pkg.sv
exe_op_if.sv
int_unit.sv
branch_unit.sv
mem_unit.sv
execution.sv
tb_execution.sv

// ==== int_unit.sv ====
`default_nettype none
`include "exe_consts.svh"

module int_unit (
    exe_op_if.unit               op,
    output logic [`EXE_XLEN-1:0] int_result_o
);
    import exe_pkg::*;

    logic [`EXE_XLEN-1:0] imm_i;
    logic [`EXE_XLEN-1:0] imm_u;
    logic [`EXE_XLEN-1:0] opb;
    logic [4:0]           shamt;
    logic                 lt_signed;
    logic                 lt_unsigned;

    // ----------------------------------------------------------
    // Operand preparation
    // ----------------------------------------------------------

    // I-type immediate, sign extended
    assign imm_i = {{(`EXE_XLEN-12){op.inst[31]}}, op.inst[31:20]};

    // U-type immediate for LUI and AUIPC
    assign imm_u = {op.inst[31:12], 12'b0};

    assign opb = op.use_imm ? imm_i : op.src2;

    // Only the low 5 bits shift on RV32
    assign shamt = opb[4:0];

    assign lt_signed   = $signed(op.src1) < $signed(opb);
    assign lt_unsigned = op.src1 < opb;

    // ----------------------------------------------------------
    // ALU
    // ----------------------------------------------------------

    always_comb begin
        case (op.alu_op)
            ALU_ADD:   int_result_o = op.src1 + opb;
            ALU_SUB:   int_result_o = op.src1 - opb;
            ALU_SLL:   int_result_o = op.src1 << shamt;
            ALU_SLT:   int_result_o = {{(`EXE_XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:  int_result_o = {{(`EXE_XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:   int_result_o = op.src1 ^ opb;
            ALU_SRL:   int_result_o = op.src1 >> shamt;
            ALU_SRA:   int_result_o = $signed(op.src1) >>> shamt;
            ALU_OR:    int_result_o = op.src1 | opb;
            ALU_AND:   int_result_o = op.src1 & opb;
            ALU_LUI:   int_result_o = imm_u;
            ALU_AUIPC: int_result_o = op.pc + imm_u;
            default:   int_result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== mem_unit.sv ====
`default_nettype none
`include "exe_consts.svh"

module mem_unit (
    input  wire                  clk_i,
    input  wire                  rst_n_i,
    exe_op_if.unit               op,
    input  wire                  xcpt_i,
    input  wire                  dmem_req_ready_i,
    input  wire                  dmem_resp_valid_i,
    input  wire                  dmem_resp_nack_i,
    input  wire [`EXE_XLEN-1:0]  dmem_resp_data_i,
    input  wire                  dmem_xcpt_ma_i,
    input  wire                  dmem_xcpt_pf_i,
    output logic                 dmem_req_valid_o,
    output logic                 dmem_req_we_o,
    output logic [1:0]           dmem_req_size_o,
    output logic [`EXE_XLEN-1:0] dmem_req_addr_o,
    output logic [`EXE_XLEN-1:0] dmem_req_data_o,
    output logic                 mem_busy_o,
    output logic                 mem_done_o,
    output logic [`EXE_XLEN-1:0] mem_data_o,
    output logic                 mem_xcpt_o
);
    import exe_pkg::*;

    mem_state_e           state_q;
    logic                 is_store;
    logic                 start;
    logic                 resp_final;
    logic [`EXE_XLEN-1:0] offset;
    logic [`EXE_XLEN-1:0] st_lanes;
    logic [`EXE_XLEN-1:0] addr_q;
    logic [`EXE_XLEN-1:0] data_q;
    logic [1:0]           size_q;
    logic                 we_q;
    logic                 uns_q;
    logic [`EXE_XLEN-1:0] word_sh;

    assign is_store = (op.unit_sel == UNIT_STORE);
    assign start = op.valid & (op.unit_sel == UNIT_LOAD || is_store) & ~xcpt_i &
                   (state_q == MEM_IDLE);

    // S-type immediate for stores, I-type for loads
    assign offset = is_store ?
        {{(`EXE_XLEN-12){op.inst[31]}}, op.inst[31:25], op.inst[11:7]} :
        {{(`EXE_XLEN-12){op.inst[31]}}, op.inst[31:20]};

    // Store data replicated over every byte lane of the word
    always_comb begin
        case (op.inst[13:12])
            2'b00:   st_lanes = {4{op.src2[7:0]}};
            2'b01:   st_lanes = {2{op.src2[15:0]}};
            default: st_lanes = op.src2;
        endcase
    end

    assign resp_final = (state_q == MEM_WAIT) & dmem_resp_valid_i & ~dmem_resp_nack_i;

    // ----------------------------------------------------------
    // Request FSM
    // ----------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= MEM_IDLE;
        end else begin
            case (state_q)
                MEM_IDLE: if (start) state_q <= MEM_REQ;
                MEM_REQ:  if (dmem_req_ready_i) state_q <= MEM_WAIT;
                MEM_WAIT: begin
                    // A nack replays the same request
                    if (dmem_resp_valid_i) begin
                        state_q <= dmem_resp_nack_i ? MEM_REQ : MEM_IDLE;
                    end
                end
                default:  state_q <= MEM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            addr_q <= op.src1 + offset;
            data_q <= st_lanes;
            size_q <= op.inst[13:12];
            we_q   <= is_store;
            uns_q  <= op.inst[14];
        end
    end

    assign dmem_req_valid_o = (state_q == MEM_REQ);
    assign dmem_req_we_o    = we_q;
    assign dmem_req_size_o  = size_q;
    assign dmem_req_addr_o  = addr_q;
    assign dmem_req_data_o  = data_q;

    // ----------------------------------------------------------
    // Response and load extension
    // ----------------------------------------------------------

    assign word_sh = dmem_resp_data_i >> {addr_q[1:0], 3'b000};

    always_comb begin
        case (size_q)
            2'b00:   mem_data_o = {{(`EXE_XLEN-8){~uns_q & word_sh[7]}}, word_sh[7:0]};
            2'b01:   mem_data_o = {{(`EXE_XLEN-16){~uns_q & word_sh[15]}}, word_sh[15:0]};
            default: mem_data_o = word_sh;
        endcase
    end

    assign mem_busy_o = (state_q != MEM_IDLE);
    assign mem_done_o = resp_final & ~(dmem_xcpt_ma_i | dmem_xcpt_pf_i);
    assign mem_xcpt_o = resp_final & (dmem_xcpt_ma_i | dmem_xcpt_pf_i);

endmodule

`default_nettype wire

// ==== tb_execution.sv ====
`default_nettype none
`include "exe_consts.svh"

module tb_execution;
    import exe_pkg::*;

    typedef struct packed {
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        taken;
        logic [31:0] target;
        logic        xcpt;
        logic [31:0] cause;
        logic [31:0] pc;
        logic [31:0] addr;
        logic [31:0] wdata;
    } exp_rec_t;

    logic        clk_i, rst_n_i, valid_i, use_imm_i, xcpt_i;
    logic [31:0] pc_i, inst_i, src1_data_i, src2_data_i, xcpt_cause_i;
    exe_unit_e   unit_i;
    alu_op_e     alu_op_i;
    logic        dmem_req_ready_i, dmem_resp_valid_i, dmem_resp_nack_i;
    logic        dmem_xcpt_ma_i, dmem_xcpt_pf_i;
    logic [31:0] dmem_resp_data_i;
    logic        exe_lock_o, wb_valid_o, wb_we_o, branch_taken_o, xcpt_o;
    logic        dmem_req_valid_o, dmem_req_we_o;
    logic [1:0]  dmem_req_size_o;
    logic [4:0]  wb_reg_o;
    logic [31:0] wb_pc_o, wb_data_o, branch_target_o, xcpt_cause_o;
    logic [31:0] dmem_req_addr_o, dmem_req_data_o;

    logic [31:0] stim_rng, cache_rng, pc_next;
    logic [31:0] ref_mem [64];
    logic [31:0] cache_mem [64];
    exp_rec_t    exp_q [$];
    exp_rec_t    last_exp;
    logic        cache_ma, cache_pf;
    int          stall_cnt;

    execution DUT (.*);

    always #50 clk_i = ~clk_i;

    function logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task fail_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp));
        end
    endtask

    // ----------------------------------------------------------
    // Reference model from the RV32 rules
    // ----------------------------------------------------------

    function exp_rec_t exe_ref(input exe_unit_e unit, input alu_op_e aop, input logic imm,
                               input logic [31:0] pc, input logic [31:0] inst,
                               input logic [31:0] s1_in, input logic [31:0] s2_in,
                               input logic xin, input logic [31:0] xcause,
                               input logic ma, input logic pf, input exp_rec_t prev);
        exp_rec_t    r;
        logic [31:0] s1, s2, b, immi, imms, immb, immj, immu, word;
        logic [2:0]  f3;
        logic        wr;
        r  = '0;
        f3 = inst[14:12];
        wr = 1'b0;
        // Previous write-back overrides a stale operand
        s1 = (prev.we && prev.rd == inst[19:15]) ? prev.data : s1_in;
        s2 = (prev.we && prev.rd == inst[24:20]) ? prev.data : s2_in;
        immi = {{20{inst[31]}}, inst[31:20]};
        imms = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        immb = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        immj = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        immu = {inst[31:12], 12'h000};
        b    = imm ? immi : s2;
        r.rd = inst[11:7];
        r.pc = pc;
        case (unit)
            UNIT_INT: begin
                wr = 1'b1;
                case (aop)
                    ALU_ADD:   r.data = s1 + b;
                    ALU_SUB:   r.data = s1 - b;
                    ALU_SLL:   r.data = s1 << b[4:0];
                    ALU_SLT:   r.data = 32'($signed(s1) < $signed(b));
                    ALU_SLTU:  r.data = 32'(s1 < b);
                    ALU_XOR:   r.data = s1 ^ b;
                    ALU_SRL:   r.data = s1 >> b[4:0];
                    ALU_SRA:   r.data = 32'($signed(s1) >>> b[4:0]);
                    ALU_OR:    r.data = s1 | b;
                    ALU_AND:   r.data = s1 & b;
                    ALU_LUI:   r.data = immu;
                    default:   r.data = pc + immu;
                endcase
            end
            UNIT_BRANCH: begin
                r.target = pc + immb;
                case (f3)
                    3'b000:  r.taken = (s1 == s2);
                    3'b001:  r.taken = (s1 != s2);
                    3'b100:  r.taken = ($signed(s1) < $signed(s2));
                    3'b101:  r.taken = ($signed(s1) >= $signed(s2));
                    3'b110:  r.taken = (s1 < s2);
                    default: r.taken = (s1 >= s2);
                endcase
            end
            UNIT_JAL, UNIT_JALR: begin
                wr       = 1'b1;
                r.taken  = 1'b1;
                r.data   = pc + 32'd4;
                r.target = (unit == UNIT_JAL) ? pc + immj : ((s1 + immi) & ~32'd1);
            end
            UNIT_LOAD: begin
                wr     = 1'b1;
                r.addr = s1 + immi;
                word   = ref_mem[r.addr[7:2]] >> (8 * r.addr[1:0]);
                case (f3[1:0])
                    2'b00:   r.data = f3[2] ? {24'h0, word[7:0]} : {{24{word[7]}}, word[7:0]};
                    2'b01:   r.data = f3[2] ? {16'h0, word[15:0]} : {{16{word[15]}}, word[15:0]};
                    default: r.data = word;
                endcase
            end
            UNIT_STORE: begin
                r.addr  = s1 + imms;
                r.wdata = s2;
            end
            UNIT_CSR: begin
                wr     = 1'b1;
                r.data = f3[2] ? {27'h0, inst[19:15]} : s1;
            end
            default: wr = 1'b0;
        endcase
        r.xcpt = 1'b1;
        if (xin)                               r.cause = xcause;
        else if (r.taken && r.target[1:0] != 0) r.cause = `CAUSE_MISALIGNED_FETCH;
        else if (unit == UNIT_STORE && ma)      r.cause = `CAUSE_MISALIGNED_STORE;
        else if (unit == UNIT_LOAD && ma)       r.cause = `CAUSE_MISALIGNED_LOAD;
        else if (unit == UNIT_STORE && pf)      r.cause = `CAUSE_FAULT_STORE;
        else if (unit == UNIT_LOAD && pf)       r.cause = `CAUSE_FAULT_LOAD;
        else                                    r.xcpt = 1'b0;
        if (r.xcpt) r.taken = 1'b0;
        r.we = wr && (r.rd != 5'd0) && !r.xcpt;
        return r;
    endfunction

    // Shadow memory follows the stores that the reference accepts
    task apply_store(input logic [31:0] addr, input logic [31:0] data, input logic [1:0] size);
        case (size)
            2'b00:   ref_mem[addr[7:2]][8*addr[1:0] +: 8] = data[7:0];
            2'b01:   ref_mem[addr[7:2]][16*addr[1] +: 16] = data[15:0];
            default: ref_mem[addr[7:2]] = data;
        endcase
    endtask

    // Called at posedge+10, returns at posedge+10 after the accepting edge
    task issue_op(input exe_unit_e unit, input alu_op_e aop, input logic imm,
                  input logic [31:0] inst, input logic [31:0] s1, input logic [31:0] s2,
                  input logic xin, input logic ma, input logic pf);
        exp_rec_t e;
        int       cnt;
        logic     mem_op;
        e = exe_ref(unit, aop, imm, pc_next, inst, s1, s2, xin, 32'd11, ma, pf, last_exp);
        exp_q.push_back(e);
        last_exp = e;
        if (unit == UNIT_STORE && !e.xcpt) apply_store(e.addr, e.wdata, inst[13:12]);
        cache_ma     = ma;
        cache_pf     = pf;
        valid_i      = 1'b1;
        unit_i       = unit;
        alu_op_i     = aop;
        use_imm_i    = imm;
        pc_i         = pc_next;
        inst_i       = inst;
        src1_data_i  = s1;
        src2_data_i  = s2;
        xcpt_i       = xin;
        xcpt_cause_i = 32'd11;
        pc_next      = pc_next + 32'd4;
        mem_op       = (unit == UNIT_LOAD || unit == UNIT_STORE) && !xin;
        cnt          = 0;
        @(negedge clk_i);
        check("exe_lock_o", 32'(exe_lock_o), 32'(mem_op));
        if (mem_op) begin
            @(negedge clk_i);
            check("dmem_req_valid_o", 32'(dmem_req_valid_o), 32'd1);
        end
        while (exe_lock_o) begin
            @(negedge clk_i);
            cnt++;
            if (cnt > 60) fail_run("exe_lock_o stayed high, the memory operation never ended");
        end
        // Lock drops only in the cycle of the final response
        if (mem_op) begin
            check("dmem_resp_valid_i at exe_lock_o fall",
                  32'(dmem_resp_valid_i & ~dmem_resp_nack_i), 32'd1);
        end
        @(posedge clk_i);
        #10;
        check("wb_valid_o", 32'(wb_valid_o), 32'd1);
    endtask

    // ----------------------------------------------------------
    // Data cache model
    // ----------------------------------------------------------

    always begin : cache_model
        logic        pend, tried, we;
        logic [31:0] addr, data;
        logic [31:0] lanes;
        logic [1:0]  size;
        logic [3:0]  mask;
        int          delay;
        @(negedge clk_i);
        if (!rst_n_i) begin
            pend  = 1'b0;
            tried = 1'b0;
        end else if (dmem_req_valid_o && dmem_req_ready_i) begin
            lanes = (inst_i[13:12] == 2'b00) ? 32'h0000_00ff :
                    (inst_i[13:12] == 2'b01) ? 32'h0000_ffff : 32'hffff_ffff;
            lanes = lanes << (8 * last_exp.addr[1:0]);
            check("dmem_req_we_o", 32'(dmem_req_we_o), 32'(unit_i == UNIT_STORE));
            check("dmem_req_size_o", 32'(dmem_req_size_o), 32'(inst_i[13:12]));
            check("dmem_req_addr_o", dmem_req_addr_o, last_exp.addr);
            if (unit_i == UNIT_STORE) begin
                check("dmem_req_data_o", dmem_req_data_o & lanes,
                      (last_exp.wdata << (8 * last_exp.addr[1:0])) & lanes);
            end
            pend  = 1'b1;
            delay = int'(cache_rng[1:0] == 2'b11);
            addr  = dmem_req_addr_o;
            data  = dmem_req_data_o;
            size  = dmem_req_size_o;
            we    = dmem_req_we_o;
        end
        @(posedge clk_i);
        #10;
        cache_rng         = xorshift(cache_rng);
        dmem_resp_valid_i = 1'b0;
        dmem_resp_nack_i  = 1'b0;
        dmem_xcpt_ma_i    = 1'b0;
        dmem_xcpt_pf_i    = 1'b0;
        dmem_resp_data_i  = '0;
        dmem_req_ready_i  = cache_rng[5:4] != 2'b00;
        if (pend && delay > 0) begin
            delay--;
        end else if (pend) begin
            pend              = 1'b0;
            dmem_resp_valid_i = 1'b1;
            if (!tried && cache_rng[9:8] == 2'b00) begin
                dmem_resp_nack_i = 1'b1;
                tried            = 1'b1;
            end else begin
                tried            = 1'b0;
                dmem_xcpt_ma_i   = cache_ma;
                dmem_xcpt_pf_i   = cache_pf;
                dmem_resp_data_i = cache_mem[addr[7:2]];
                mask = (size == 2'b00) ? 4'b0001 << addr[1:0] :
                       (size == 2'b01) ? 4'b0011 << addr[1:0] : 4'b1111;
                for (int i = 0; i < 4; i++) begin
                    if (we && !cache_ma && !cache_pf && mask[i]) begin
                        cache_mem[addr[7:2]][8*i +: 8] = data[8*i +: 8];
                    end
                end
            end
        end
    end

    // ----------------------------------------------------------
    // Write-back compare and retire watchdog
    // ----------------------------------------------------------

    always @(negedge clk_i) begin : compare_wb
        exp_rec_t e;
        if (rst_n_i && wb_valid_o) begin
            if (exp_q.size() == 0) fail_run("wb_valid_o rose with no instruction pending");
            e = exp_q.pop_front();
            check("wb_pc_o", wb_pc_o, e.pc);
            check("wb_we_o", 32'(wb_we_o), 32'(e.we));
            if (e.we) begin
                check("wb_reg_o", 32'(wb_reg_o), 32'(e.rd));
                check("wb_data_o", wb_data_o, e.data);
            end
            check("xcpt_o", 32'(xcpt_o), 32'(e.xcpt));
            if (e.xcpt) check("xcpt_cause_o", xcpt_cause_o, e.cause);
            check("branch_taken_o", 32'(branch_taken_o), 32'(e.taken));
            if (e.taken) check("branch_target_o", branch_target_o, e.target);
        end
    end

    always @(negedge clk_i) begin
        stall_cnt = (exp_q.size() != 0 && !wb_valid_o) ? stall_cnt + 1 : 0;
        if (stall_cnt > 80) fail_run("an issued instruction got no wb_valid_o in time");
    end

    // ----------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------

    initial begin
        logic [31:0] r, inst, s1, s2;
        logic [11:0] off;
        logic [2:0]  f3;
        exe_unit_e   unit;
        int          cnt;
        clk_i = 1'b0;
        rst_n_i = 1'b0;
        valid_i = 1'b0;
        use_imm_i = 1'b0;
        xcpt_i = 1'b0;
        unit_i = UNIT_NONE;
        alu_op_i = ALU_ADD;
        pc_i = '0;
        inst_i = '0;
        src1_data_i = '0;
        src2_data_i = '0;
        xcpt_cause_i = '0;
        dmem_req_ready_i = 1'b0;
        dmem_resp_valid_i = 1'b0;
        dmem_resp_nack_i = 1'b0;
        dmem_resp_data_i = '0;
        dmem_xcpt_ma_i = 1'b0;
        dmem_xcpt_pf_i = 1'b0;
        cache_ma = 1'b0;
        cache_pf = 1'b0;
        stall_cnt = 0;
        last_exp = '0;
        pc_next = 32'h0000_1000;
        stim_rng = 32'h5681;
        cache_rng = xorshift(32'h5681);
        for (int i = 0; i < 64; i++) begin
            ref_mem[i]   = 32'h9E37_79B9 * (i + 1) ^ (i << 24);
            cache_mem[i] = 32'h9E37_79B9 * (i + 1) ^ (i << 24);
        end
        repeat (3) @(posedge clk_i);
        #10 rst_n_i = 1'b1;
        check("wb_valid_o", 32'(wb_valid_o), 32'd0);
        check("wb_we_o", 32'(wb_we_o), 32'd0);
        check("xcpt_o", 32'(xcpt_o), 32'd0);
        check("branch_taken_o", 32'(branch_taken_o), 32'd0);
        check("dmem_req_valid_o", 32'(dmem_req_valid_o), 32'd0);
        check("exe_lock_o", 32'(exe_lock_o), 32'd0);

        // Dependent pair, then a misaligned JAL that also carries xcpt_i
        issue_op(UNIT_INT, ALU_ADD, 1'b1, 32'h0070_0293, 32'd100, 32'd0, 1'b0, 1'b0, 1'b0);
        issue_op(UNIT_INT, ALU_ADD, 1'b0, 32'h0052_82b3, 32'd0, 32'd0, 1'b0, 1'b0, 1'b0);
        issue_op(UNIT_JAL, ALU_ADD, 1'b0, 32'h0020_00ef, 32'd0, 32'd0, 1'b1, 1'b0, 1'b0);

        for (int n = 0; n < 900; n++) begin
            stim_rng = xorshift(stim_rng);
            r = stim_rng;
            stim_rng = xorshift(stim_rng);
            inst = stim_rng;
            inst[11:7]  = {2'b00, r[2:0]};
            inst[19:15] = {2'b00, r[5:3]};
            inst[24:20] = {2'b00, r[8:6]};
            s1 = xorshift(r ^ 32'h1234_5678);
            s2 = xorshift(s1);
            case (r[12:10])
                3'd0, 3'd1: unit = UNIT_INT;
                3'd2:       unit = UNIT_BRANCH;
                3'd3:       unit = r[13] ? UNIT_JAL : UNIT_JALR;
                3'd4:       unit = UNIT_LOAD;
                3'd5:       unit = UNIT_STORE;
                3'd6:       unit = UNIT_CSR;
                default:    unit = UNIT_NONE;
            endcase
            if (unit == UNIT_BRANCH) begin
                f3 = (r[16:14] == 3'd2 || r[16:14] == 3'd3) ? 3'd0 : r[16:14];
                inst[14:12] = f3;
                s1 = r[18] ? {r[17], 31'h0} : {{31{r[17]}}, 1'b1};
                s2 = r[20] ? {r[19], 31'h0} : {{31{r[19]}}, 1'b1};
            end
            if (unit == UNIT_LOAD || unit == UNIT_STORE) begin
                // Base from x0, offset aligned to the access size
                f3 = (unit == UNIT_STORE) ? {1'b0, r[15:14] == 2'd3 ? 2'd2 : r[15:14]} :
                     (r[16:14] == 3'd3 || r[16:14] > 3'd5) ? 3'd2 : r[16:14];
                inst[14:12] = f3;
                inst[19:15] = 5'd0;
                off = {6'h00, r[22:17]} & (f3[1] ? 12'hffc : f3[0] ? 12'hffe : 12'hfff);
                s1 = {24'h0, r[24:23], 6'h00};
                if (unit == UNIT_LOAD) inst[31:20] = off;
                else {inst[31:25], inst[11:7]} = off;
            end
            // Cache misaligned and fault flags sometimes come together
            issue_op(unit, alu_op_e'(r[29:26] % 4'd12), r[25], inst, s1, s2,
                     r[31:27] == 5'd0, r[31:27] == 5'd1 || r[31:27] == 5'd3,
                     r[31:27] == 5'd2 || r[31:27] == 5'd3);
        end
        valid_i = 1'b0;
        cnt = 0;
        while (exp_q.size() != 0 && cnt < 100) begin
            @(negedge clk_i);
            cnt++;
        end
        if (exp_q.size() == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            fail_run("instructions were left without a write-back at the end");
        end
    end

endmodule

`default_nettype wire
